//--- hw/sd_pkg.sv
package sd_pkg;

    // ============================================================
    // frame geometry
    // ============================================================

    // command index width
    localparam int idx_w        = 6;
    // index plus 32-bit argument
    localparam int cmd_w        = 38;
    localparam int cmd_frame_w  = 48;
    localparam int resp_short_w = 48;
    // long response, also the width of resp_data
    localparam int resp_long_w  = 136;
    // leading frame bits covered by crc7
    localparam int crc_span     = 40;
    // bit 0 timeout, bit 1 crc error
    localparam int status_w     = 2;

    // ============================================================
    // timing
    // ============================================================

    // clk cycles per half period of sd_clk
    localparam int sd_div  = 2;
    // bit times to wait for a response start bit
    localparam int ncr_max = 64;

    // counter widths
    localparam int div_cnt_w = (sd_div > 1) ? $clog2(sd_div) : 1;
    localparam int tx_cnt_w  = $clog2(cmd_frame_w + 1);
    localparam int rx_cnt_w  = $clog2(resp_long_w);

    // response kinds
    typedef enum logic [1:0] {resp_none, resp_short, resp_long} resp_kind_t;

    // cmd0 silent, cmd2/9/10 long, rest short
    function automatic resp_kind_t resp_kind_of(input logic [idx_w-1:0] idx);
        case (idx)
            6'd0:               return resp_none;
            6'd2, 6'd9, 6'd10:  return resp_long;
            default:            return resp_short;
        endcase
    endfunction

endpackage

//--- hw/sd_crc7.sv
module sd_crc7 (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       bit_en,
    input  logic       din,
    output logic [6:0] crc
);

    // feedback taken from the top bit
    logic fb;

    assign fb = din ^ crc[6];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '0;
        end else if (clear) begin
            // new frame starts from zero
            crc <= '0;
        end else if (bit_en) begin
            // x^7 + x^3 + 1, msb first
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

endmodule

//--- hw/sd_clk_div.sv
module sd_clk_div (
    input  logic clk,
    input  logic rst_n,
    output logic sd_clk,
    output logic tick_rise,
    output logic tick_fall
);

    import sd_pkg::*;

    // half-period counter
    logic [div_cnt_w-1:0] cnt;
    // last cycle of the half period
    logic                 wrap;

    assign wrap = (cnt == div_cnt_w'(sd_div - 1));

    // ticks flag the cycle whose edge flips sd_clk
    assign tick_rise = wrap & ~sd_clk;
    assign tick_fall = wrap & sd_clk;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            sd_clk <= 1'b0;
        end else if (wrap) begin
            cnt    <= '0;
            sd_clk <= ~sd_clk;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- hw/sd_cmd_tx.sv
module sd_cmd_tx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     tick_fall,
    input  logic                     tx_start,
    input  logic [sd_pkg::cmd_w-1:0] tx_payload,
    output logic                     cmd_out,
    output logic                     cmd_oe,
    output logic                     tx_done
);

    import sd_pkg::*;

    // frame shifter, msb leaves first
    logic [crc_span-1:0] sreg;
    // bit time index within the frame
    logic [tx_cnt_w-1:0] bit_cnt;
    logic                busy;
    logic                crc_en;
    logic [6:0]          crc;

    // crc sees start, transmission and payload bits only
    assign crc_en = tick_fall & busy & (bit_cnt < tx_cnt_w'(crc_span));

    sd_crc7 i_sd_crc7 (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (tx_start),
        .bit_en (crc_en),
        .din    (sreg[crc_span-1]),
        .crc    (crc)
    );

    // ============================================================
    // shift register
    // ============================================================
    always_ff @(posedge clk) begin
        if (tx_start) begin
            // start 0, transmission 1, then index and argument
            sreg <= {2'b01, tx_payload};
        end else if (tick_fall && busy) begin
            if (bit_cnt == tx_cnt_w'(crc_span)) begin
                // crc[6] goes out now, rest of crc and end bit queue up
                sreg <= {crc[5:0], 1'b1, {(crc_span - 7){1'b0}}};
            end else begin
                sreg <= sreg << 1;
            end
        end
    end

    // ============================================================
    // line control
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            cmd_out <= 1'b1;
            cmd_oe  <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (tx_start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (tick_fall && busy) begin
                if (bit_cnt == tx_cnt_w'(cmd_frame_w)) begin
                    // end bit time is over, let go of the line
                    busy    <= 1'b0;
                    cmd_oe  <= 1'b0;
                    cmd_out <= 1'b1;
                    tx_done <= 1'b1;
                end else begin
                    cmd_oe  <= 1'b1;
                    cmd_out <= (bit_cnt == tx_cnt_w'(crc_span)) ? crc[6] : sreg[crc_span-1];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/sd_resp_rx.sv
module sd_resp_rx (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           tick_rise,
    input  logic                           cmd_in,
    input  logic                           rx_start,
    input  sd_pkg::resp_kind_t             rx_kind,
    output logic                           rx_done,
    output logic [sd_pkg::resp_long_w-1:0] rx_data,
    output logic                           rx_timeout,
    output logic                           rx_crc_err
);

    import sd_pkg::*;

    typedef enum logic [1:0] {st_idle, st_search, st_shift} rx_state_t;

    rx_state_t           state;
    resp_kind_t          kind;
    // wait ticks while searching, bit index while shifting
    logic [rx_cnt_w-1:0] cnt;
    logic [rx_cnt_w-1:0] last_bit;
    logic                start_seen;
    logic                crc_en;
    logic [6:0]          crc;

    assign last_bit = (kind == resp_long) ? rx_cnt_w'(resp_long_w - 1)
                                          : rx_cnt_w'(resp_short_w - 1);

    // card pulls the line low to open a response
    assign start_seen = (state == st_search) & tick_rise & ~cmd_in;

    // crc over bits 47..8 of a short response
    assign crc_en = start_seen
                  | (tick_rise & (state == st_shift) & (cnt < rx_cnt_w'(crc_span)));

    sd_crc7 i_sd_crc7 (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (rx_start),
        .bit_en (crc_en),
        .din    (cmd_in),
        .crc    (crc)
    );

    // ============================================================
    // data shifter, right aligned, start bit included
    // ============================================================
    always_ff @(posedge clk) begin
        if (rx_start) begin
            rx_data <= '0;
        end else if (start_seen || (tick_rise && state == st_shift)) begin
            rx_data <= {rx_data[resp_long_w-2:0], cmd_in};
        end
    end

    // ============================================================
    // search and count
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            kind       <= resp_short;
            cnt        <= '0;
            rx_done    <= 1'b0;
            rx_timeout <= 1'b0;
            rx_crc_err <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (rx_start) begin
                        kind  <= rx_kind;
                        cnt   <= '0;
                        state <= st_search;
                    end
                end
                st_search: begin
                    if (start_seen) begin
                        // start bit already counts as bit 0
                        cnt   <= rx_cnt_w'(1);
                        state <= st_shift;
                    end else if (tick_rise && cnt == rx_cnt_w'(ncr_max - 1)) begin
                        // no start bit within ncr_max
                        rx_done    <= 1'b1;
                        rx_timeout <= 1'b1;
                        rx_crc_err <= 1'b0;
                        state      <= st_idle;
                    end else if (tick_rise) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_shift: begin
                    if (tick_rise && cnt == last_bit) begin
                        // end bit arrives now, rx_data[6:0] holds received crc
                        rx_done    <= 1'b1;
                        rx_timeout <= 1'b0;
                        rx_crc_err <= (kind == resp_short) && (crc != rx_data[6:0]);
                        state      <= st_idle;
                    end else if (tick_rise) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- hw/sd_cmd_ctrl.sv
module sd_cmd_ctrl (
    // command side
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  logic [sd_pkg::cmd_w-1:0]       cmd_data,
    // transmitter side
    output logic                           tx_start,
    output logic [sd_pkg::cmd_w-1:0]       tx_payload,
    input  logic                           tx_done,
    // receiver side
    output logic                           rx_start,
    output sd_pkg::resp_kind_t             rx_kind,
    input  logic                           rx_done,
    input  logic [sd_pkg::resp_long_w-1:0] rx_data,
    input  logic                           rx_timeout,
    input  logic                           rx_crc_err,
    // response side
    output logic                           resp_valid,
    input  logic                           resp_ready,
    output logic [sd_pkg::resp_long_w-1:0] resp_data,
    output logic [sd_pkg::status_w-1:0]    resp_status
);

    import sd_pkg::*;

    typedef enum logic [1:0] {st_idle, st_send, st_recv, st_report} ctrl_state_t;

    ctrl_state_t state;

    // one command in flight at a time
    assign cmd_ready  = (state == st_idle);
    assign resp_valid = (state == st_report);

    // ============================================================
    // payload registers
    // ============================================================
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            tx_payload <= cmd_data;
        end
        if (state == st_send && tx_done && rx_kind == resp_none) begin
            // cmd0 reports empty
            resp_data   <= '0;
            resp_status <= '0;
        end else if (state == st_recv && rx_done) begin
            resp_data   <= rx_data;
            resp_status <= {rx_crc_err, rx_timeout};
        end
    end

    // ============================================================
    // sequencer FSM
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            rx_kind  <= resp_none;
            tx_start <= 1'b0;
            rx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            rx_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        // kind decided from the index on accept
                        rx_kind  <= resp_kind_of(cmd_data[cmd_w-1 -: idx_w]);
                        tx_start <= 1'b1;
                        state    <= st_send;
                    end
                end
                st_send: begin
                    if (tx_done && rx_kind == resp_none) begin
                        state <= st_report;
                    end else if (tx_done) begin
                        rx_start <= 1'b1;
                        state    <= st_recv;
                    end
                end
                st_recv: begin
                    if (rx_done) begin
                        state <= st_report;
                    end
                end
                st_report: begin
                    // hold response until taken
                    if (resp_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- hw/sd_cmd_host.sv
module sd_cmd_host (
    input  logic                           clk,
    input  logic                           rst_n,
    // command port
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  logic [sd_pkg::cmd_w-1:0]       cmd_data,
    // response port
    output logic                           resp_valid,
    input  logic                           resp_ready,
    output logic [sd_pkg::resp_long_w-1:0] resp_data,
    output logic [sd_pkg::status_w-1:0]    resp_status,
    // card pin side
    output logic                           sd_clk,
    output logic                           cmd_out,
    output logic                           cmd_oe,
    input  logic                           cmd_in
);

    import sd_pkg::*;

    // ============================================================
    // internal wiring
    // ============================================================
    logic                   tick_rise;
    logic                   tick_fall;
    logic                   tx_start;
    logic [cmd_w-1:0]       tx_payload;
    logic                   tx_done;
    logic                   rx_start;
    resp_kind_t             rx_kind;
    logic                   rx_done;
    logic [resp_long_w-1:0] rx_data;
    logic                   rx_timeout;
    logic                   rx_crc_err;

    // bit clock and edge ticks
    sd_clk_div i_sd_clk_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .sd_clk    (sd_clk),
        .tick_rise (tick_rise),
        .tick_fall (tick_fall)
    );

    // drives on falling edges
    sd_cmd_tx i_sd_cmd_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick_fall  (tick_fall),
        .tx_start   (tx_start),
        .tx_payload (tx_payload),
        .cmd_out    (cmd_out),
        .cmd_oe     (cmd_oe),
        .tx_done    (tx_done)
    );

    // samples on rising edges
    sd_resp_rx i_sd_resp_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick_rise  (tick_rise),
        .cmd_in     (cmd_in),
        .rx_start   (rx_start),
        .rx_kind    (rx_kind),
        .rx_done    (rx_done),
        .rx_data    (rx_data),
        .rx_timeout (rx_timeout),
        .rx_crc_err (rx_crc_err)
    );

    sd_cmd_ctrl i_sd_cmd_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_data    (cmd_data),
        .tx_start    (tx_start),
        .tx_payload  (tx_payload),
        .tx_done     (tx_done),
        .rx_start    (rx_start),
        .rx_kind     (rx_kind),
        .rx_done     (rx_done),
        .rx_data     (rx_data),
        .rx_timeout  (rx_timeout),
        .rx_crc_err  (rx_crc_err),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_data   (resp_data),
        .resp_status (resp_status)
    );

endmodule

//--- dv/sd_card_model.sv
module sd_card_model (
    input  logic                           sd_clk,
    input  logic                           cmd_out,
    input  logic                           cmd_oe,
    // per-command behavior
    input  int                             delay,
    input  logic                           suppress,
    input  logic                           corrupt,
    output logic                           cmd_in,
    output logic [sd_pkg::cmd_frame_w-1:0] frame,
    output int                             frame_count
);

    timeunit 1ns;
    timeprecision 100ps;

    import sd_pkg::*;

    logic [cmd_frame_w-1:0]  shift_in;
    logic [resp_long_w-1:0]  resp;
    logic [resp_short_w-1:0] short_resp;
    // long payload, argument repeated to 120 bits
    logic [119:0]            body;
    logic [5:0]              idx;
    logic [31:0]             arg;
    logic [6:0]              crc;
    int                      bits;
    int                      resp_len;
    int                      i;

    // crc7 over the low n bits, msb first
    function automatic logic [6:0] crc7_of(input logic [119:0] data, input int n);
        logic [6:0] c;
        logic       fb;
        int         k;
        c = '0;
        for (k = n - 1; k >= 0; k--) begin
            fb = data[k] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    initial begin
        cmd_in      = 1'b1;
        frame       = '0;
        frame_count = 0;
        shift_in    = '0;
        forever begin
            // ====================================================
            // capture one host frame on rising sd_clk
            // ====================================================
            bits = 0;
            while (bits < cmd_frame_w) begin
                @(posedge sd_clk);
                if (cmd_oe) begin
                    shift_in = {shift_in[cmd_frame_w-2:0], cmd_out};
                    bits++;
                end
            end
            frame       <= shift_in;
            frame_count <= frame_count + 1;
            idx = shift_in[45:40];
            arg = shift_in[39:8];
            // cmd0 and suppressed commands stay silent
            if (idx != 6'd0 && !suppress) begin
                if (idx == 6'd2 || idx == 6'd9 || idx == 6'd10) begin
                    body     = {arg, arg, arg, arg[31:8]};
                    crc      = crc7_of(body, 120);
                    resp     = {2'b00, 6'b111111, body, crc, 1'b1};
                    resp_len = resp_long_w;
                end else begin
                    short_resp = {2'b00, idx, ~arg, 7'h00, 1'b1};
                    crc        = crc7_of({80'b0, short_resp[47:8]}, 40);
                    if (corrupt) begin
                        crc = ~crc;
                    end
                    short_resp[7:1] = crc;
                    resp            = {88'b0, short_resp};
                    resp_len        = resp_short_w;
                end
                // response bits change on falling sd_clk
                repeat (delay) @(negedge sd_clk);
                for (i = resp_len - 1; i >= 0; i--) begin
                    cmd_in <= resp[i];
                    @(negedge sd_clk);
                end
                cmd_in <= 1'b1;
            end
        end
    end

endmodule

//--- dv/sd_cmd_checker.sv
module sd_cmd_checker (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           cmd_valid,
    input logic                           cmd_ready,
    input logic [sd_pkg::cmd_w-1:0]       cmd_data,
    input logic                           resp_valid,
    input logic                           resp_ready,
    input logic [sd_pkg::resp_long_w-1:0] resp_data,
    input logic [sd_pkg::status_w-1:0]    resp_status,
    input logic                           cmd_out,
    input logic                           cmd_oe,
    input logic                           tick_fall,
    input logic                           rx_start,
    input logic                           rx_done
);

    timeunit 1ns;
    timeprecision 100ps;

    // high from receiver start until its done pulse
    logic awaiting_resp;
    // assertion failures so far
    int   fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awaiting_resp <= 1'b0;
        end else if (rx_start) begin
            awaiting_resp <= 1'b1;
        end else if (rx_done) begin
            awaiting_resp <= 1'b0;
        end
    end

    // ============================================================
    // handshake rules on both ports
    // ============================================================
    cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data))
        else begin
            $error("command valid dropped or data changed before ready");
            fail_count++;
        end

    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data)
                                      && $stable(resp_status))
        else begin
            $error("response valid dropped or payload changed before ready");
            fail_count++;
        end

    // line released while the card answers
    oe_released: assert property (@(posedge clk) disable iff (!rst_n)
        awaiting_resp |-> !cmd_oe)
        else begin
            $error("cmd_oe high while waiting for a response");
            fail_count++;
        end

    // driven bits move only with falling sd_clk
    out_on_fall: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_out != $past(cmd_out) |-> $past(tick_fall))
        else begin
            $error("cmd_out changed outside a tick_fall cycle");
            fail_count++;
        end

endmodule

//--- dv/tb_sd_cmd_host.sv
module tb_sd_cmd_host;

    timeunit 1ns;
    timeprecision 100ps;

    import sd_pkg::*;

    localparam int num_cmds     = 200;
    localparam int accept_limit = 20;
    localparam int resp_limit   = 4000;

    logic                   clk;
    logic                   rst_n;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic [cmd_w-1:0]       cmd_data;
    logic                   resp_valid;
    logic                   resp_ready;
    logic [resp_long_w-1:0] resp_data;
    logic [status_w-1:0]    resp_status;
    logic                   sd_clk;
    logic                   cmd_out;
    logic                   cmd_oe;
    logic                   cmd_in;

    // card controls and capture
    int                     card_delay;
    logic                   card_suppress;
    logic                   card_corrupt;
    logic [cmd_frame_w-1:0] card_frame;
    int                     frame_count;

    integer                 seed       = 64;
    integer                 ready_seed = 64;
    int                     hold_left  = 0;
    int                     cmd_index;
    logic [cmd_w-1:0]       cmd;
    logic                   sup;
    logic                   bad;
    int                     delay;
    logic [cmd_w-1:0]       next_cmd;
    logic                   next_sup;
    logic                   next_bad;
    int                     next_delay;
    logic [cmd_frame_w-1:0] exp_frame;
    logic [resp_long_w-1:0] exp_data;
    logic [status_w-1:0]    exp_status;
    logic [resp_long_w-1:0] got_data;
    logic [status_w-1:0]    got_status;

    sd_cmd_host i_sd_cmd_host (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_data    (cmd_data),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_data   (resp_data),
        .resp_status (resp_status),
        .sd_clk      (sd_clk),
        .cmd_out     (cmd_out),
        .cmd_oe      (cmd_oe),
        .cmd_in      (cmd_in)
    );

    sd_card_model i_sd_card_model (
        .sd_clk      (sd_clk),
        .cmd_out     (cmd_out),
        .cmd_oe      (cmd_oe),
        .delay       (card_delay),
        .suppress    (card_suppress),
        .corrupt     (card_corrupt),
        .cmd_in      (cmd_in),
        .frame       (card_frame),
        .frame_count (frame_count)
    );

    bind sd_cmd_host sd_cmd_checker i_sd_cmd_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_data    (cmd_data),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_data   (resp_data),
        .resp_status (resp_status),
        .cmd_out     (cmd_out),
        .cmd_oe      (cmd_oe),
        .tick_fall   (tick_fall),
        .rx_start    (rx_start),
        .rx_done     (rx_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // back-pressure, resp_ready held for random runs
    always @(posedge clk) begin : ready_gen
        logic [31:0] roll;
        if (hold_left == 0) begin
            roll = $random(ready_seed);
            resp_ready <= (roll[1:0] != 2'd0);
            hold_left  <= 1 + int'(roll[6:3]);
        end else begin
            hold_left <= hold_left - 1;
        end
    end

    // ============================================================
    // reference model
    // ============================================================

    // x^7 + x^3 + 1 over the low n bits, msb first
    function automatic logic [6:0] calc_crc7(input logic [119:0] data, input int n);
        logic [6:0] c;
        logic       fb;
        int         k;
        c = '0;
        for (k = n - 1; k >= 0; k--) begin
            fb = data[k] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    function automatic logic [cmd_frame_w-1:0] predict_frame(input logic [cmd_w-1:0] c);
        return {2'b01, c, calc_crc7({80'b0, 2'b01, c}, 40), 1'b1};
    endfunction

    task automatic predict_response(input logic [cmd_w-1:0] c, input logic no_answer,
                                    input logic crc_flip,
                                    output logic [resp_long_w-1:0] data,
                                    output logic [status_w-1:0] status);
        resp_kind_t   kind;
        logic [119:0] body;
        logic [39:0]  head;
        logic [6:0]   crc;
        kind = (c[37:32] == 6'd0) ? resp_none
             : (c[37:32] == 6'd2 || c[37:32] == 6'd9 || c[37:32] == 6'd10) ? resp_long
             : resp_short;
        data   = '0;
        status = '0;
        if (kind == resp_none) begin
            // cmd0 reports empty
            status = '0;
        end else if (no_answer) begin
            status = 2'b01;
        end else if (kind == resp_long) begin
            body = {c[31:0], c[31:0], c[31:0], c[31:8]};
            data = {2'b00, 6'b111111, body, calc_crc7(body, 120), 1'b1};
        end else begin
            head = {2'b00, c[37:32], ~c[31:0]};
            crc  = calc_crc7({80'b0, head}, 40);
            if (crc_flip) begin
                crc = ~crc;
            end
            data   = {88'b0, head, crc, 1'b1};
            status = {crc_flip, 1'b0};
        end
    endtask

    // random command and card behavior, biased toward cmd0 and long indices
    task automatic draw_command(output logic [cmd_w-1:0] c, output logic no_answer,
                                output logic crc_flip, output int wait_bits);
        logic [31:0] r;
        logic [5:0]  i;
        logic [31:0] a;
        r = $random(seed);
        case (r[2:0])
            3'd0:    i = 6'd0;
            3'd1:    i = (r[4:3] == 2'd0) ? 6'd2 : (r[4:3] == 2'd1) ? 6'd9 : 6'd10;
            default: i = r[10:5];
        endcase
        a = $random(seed);
        r = $random(seed);
        c         = {i, a};
        no_answer = (r[10:8] == 3'd0);
        crc_flip  = (r[13:12] == 2'd0);
        wait_bits = 2 + int'(r[7:0] % 8'd7);
    endtask

    // ============================================================
    // checks and port tasks
    // ============================================================
    task automatic check_eq(input logic [135:0] actual, input logic [135:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no %s within the cycle limit", what);
        $display(">>> FAIL");
        $fatal(1, "wait limit reached");
    endtask

    task automatic issue_command(input logic [cmd_w-1:0] data);
        int waited;
        waited = 0;
        cmd_valid <= 1'b1;
        cmd_data  <= data;
        do begin
            @(posedge clk);
            waited++;
            check_eq(136'(resp_valid), 136'(0), "resp_valid while idle");
            if (waited > accept_limit) begin
                report_timeout("cmd_ready for a new command");
            end
        end while (!cmd_ready);
        cmd_valid <= 1'b0;
        cmd_data  <= '0;
        // ready is back one cycle after the previous response
        check_eq(136'(waited), 136'(1), "cycles until accept");
    endtask

    task automatic await_response(input logic [cmd_w-1:0] next, input logic offer,
                                  output logic [resp_long_w-1:0] data,
                                  output logic [status_w-1:0] status);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            check_eq(136'(cmd_ready), 136'(0), "cmd_ready during a command");
            if (offer && resp_valid && !resp_ready) begin
                // next command waits on the port while the response is held
                cmd_valid <= 1'b1;
                cmd_data  <= next;
            end
            if (waited > resp_limit) begin
                report_timeout("response transfer");
            end
        end while (!(resp_valid && resp_ready));
        data   = resp_data;
        status = resp_status;
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd_data      = '0;
        resp_ready    = 1'b0;
        card_delay    = 2;
        card_suppress = 1'b0;
        card_corrupt  = 1'b0;
        repeat (3) @(posedge clk);
        check_eq(136'(cmd_out), 136'(1), "cmd_out in reset");
        check_eq(136'(cmd_oe), 136'(0), "cmd_oe in reset");
        check_eq(136'(resp_valid), 136'(0), "resp_valid in reset");
        rst_n <= 1'b1;
        draw_command(cmd, sup, bad, delay);
        for (cmd_index = 0; cmd_index < num_cmds; cmd_index++) begin
            card_delay    <= delay;
            card_suppress <= sup;
            card_corrupt  <= bad;
            exp_frame = predict_frame(cmd);
            predict_response(cmd, sup, bad, exp_data, exp_status);
            issue_command(cmd);
            draw_command(next_cmd, next_sup, next_bad, next_delay);
            await_response(next_cmd, cmd_index < num_cmds - 1, got_data, got_status);
            check_eq(136'(frame_count), 136'(cmd_index + 1), "frames seen by card");
            check_eq(136'(card_frame), 136'(exp_frame), "command frame");
            check_eq(got_data, exp_data, "resp_data");
            check_eq(136'(got_status), 136'(exp_status), "resp_status");
            cmd   = next_cmd;
            sup   = next_sup;
            bad   = next_bad;
            delay = next_delay;
        end
        if (i_sd_cmd_host.i_sd_cmd_checker.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

//--- tb.f
hw/sd_pkg.sv
hw/sd_crc7.sv
hw/sd_clk_div.sv
hw/sd_cmd_tx.sv
hw/sd_resp_rx.sv
hw/sd_cmd_ctrl.sv
hw/sd_cmd_host.sv
dv/sd_card_model.sv
dv/sd_cmd_checker.sv
dv/tb_sd_cmd_host.sv

//--- Makefile
# Verilator build for the SD command host testbench
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR   ?= verilator
TOP         ?= tb_sd_cmd_host
FILELIST    ?= tb.f
BUILD_DIR   ?= obj_dir
TIMESCALE   ?= 1ns/100ps
VFLAGS      ?= --binary --timing --assert -j 0
EXTRA_FLAGS ?=
SIM_ARGS    ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --timescale $(TIMESCALE) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the result
run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
